/* include/fp16Defs.svh */
// binary16 field sizes and bias only; the pipeline logic assumes these exact values
`ifndef FP16_DEFS_SVH
`define FP16_DEFS_SVH

// ------------------------------
// IEEE 754 binary16 layout
// ------------------------------

// biased exponent field width
`define fpExpWidth 5

// stored fraction width, hidden bit not counted
`define fpFracWidth 10

// exponent bias
`define fpBias 15

`endif

/* hdl/fp16Pkg.sv */
// shared binary16 types; no NaN encodings are produced, all-ones exponent always means infinity
`include "fp16Defs.svh"

package fp16Pkg;

	localparam int EMSB = `fpExpWidth - 1;                     // top exponent bit
	localparam int FMSB = `fpFracWidth - 1;                    // top fraction bit
	localparam int MSB  = `fpExpWidth + `fpFracWidth;          // sign bit of the word
	localparam int BIAS = `fpBias;
	localparam int expRawWidth = 7;                            // signed raw exponent in

	// rounding modes, encoding as on the rm input of the rounder
	typedef enum logic [2:0] {
		rmNearestEven = 3'd0,
		rmZero        = 3'd1,
		rmPlusInf     = 3'd2,
		rmMinusInf    = 3'd3,
		rmNearestAway = 3'd4
	} roundMode_t;

	typedef struct packed {
		logic            sign;
		logic [EMSB:0]   exp;
		logic [FMSB:0]   sig;   // fraction only, hidden bit implied
	} fp16Fields_t;

	// one binary16 word, seen as fields or as raw bits
	typedef union packed {
		fp16Fields_t    f;
		logic [MSB:0]   raw;
	} FP16;

	// intermediate word between normalizer and rounder
	// sig is leading bit, fraction, guard, round, sticky
	typedef struct packed {
		logic            sign;
		logic [EMSB:0]   exp;
		logic [FMSB+4:0] sig;
	} FP16N;

endpackage

/* hdl/fpNormalize16.sv */
// value taken as mag * 2^(expRaw-rawWidth+1), so the top bit of mag weighs 2^expRaw; overflow saturates to infinity in every mode
`timescale 1ns/100ps

module fpNormalize16 import fp16Pkg::*; #(
	parameter int rawWidth = 24
) (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          ce,
	input  logic                          sign,
	input  logic signed [expRawWidth-1:0] expRaw,
	input  logic [rawWidth-1:0]           mag,
	input  logic                          special,
	output FP16N                          normWord,
	output logic                          normSpecial
);

	localparam int lzW  = $clog2(rawWidth + 1);        // leading zero count width
	localparam int eW   = expRawWidth + lzW + 2;       // room for bias and shift
	localparam int padW = 15;                          // zeros below mag, > max denorm shift
	localparam int wW   = rawWidth + padW;
	localparam int shW  = $clog2(padW + 1);

	logic [lzW-1:0]        lz;
	logic [rawWidth-1:0]   magShl;
	logic signed [eW-1:0]  expAdj;      // biased exponent of the leading one
	logic signed [eW-1:0]  denormAmt;
	logic [shW-1:0]        dsh;
	logic [wW-1:0]         wide;
	logic [wW-1:0]         wideDn;
	FP16N                  nextWord;

	// ------------------------------
	// leading one and exponent
	// ------------------------------
	always_comb begin
		lz = '0;
		for (int k = 0; k < rawWidth; k++)
			if (mag[k])
				lz = lzW'(rawWidth - 1 - k);   // highest set bit wins
	end

	assign magShl = mag << lz;                      // leading one now at the top
	assign expAdj = eW'(expRaw) + eW'(BIAS) - eW'(lz);

	// right shift into subnormal range, clamped once all bits land in sticky
	assign denormAmt = eW'(1) - expAdj;
	assign dsh    = (denormAmt > eW'(padW)) ? shW'(padW) : denormAmt[shW-1:0];
	assign wide   = {magShl, {padW{1'b0}}};
	assign wideDn = wide >> dsh;

	// ------------------------------
	// next intermediate word
	// ------------------------------
	always_comb begin
		nextWord = '0;
		nextWord.sign = sign;
		if (special) begin
			nextWord.exp = '1;                      // inf or NaN passed as inf
		end
		else if (mag == '0) begin
			nextWord.sign = 1'b0;                   // clean +0
		end
		else if (expAdj >= eW'(2 ** (EMSB + 1) - 1)) begin
			nextWord.exp = '1;                      // out of range, saturate
		end
		else if (expAdj <= eW'(1)) begin
			// exp 0, a leading bit left set means smallest normal
			nextWord.exp = '0;
			nextWord.sig = {wideDn[wW-1 -: FMSB+4], |wideDn[wW-FMSB-5:0]};
		end
		else begin
			nextWord.exp = expAdj[EMSB:0];
			nextWord.sig = {wide[wW-1 -: FMSB+4], |wide[wW-FMSB-5:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			normWord    <= '0;
			normSpecial <= 1'b0;
		end
		else if (ce) begin
			normWord    <= nextWord;
			normSpecial <= special;
		end
	end

endmodule

/* hdl/fpRound16.sv */
// expects FP16N from fpNormalize16; an exp of 0 with the leading bit set is read as exponent 1
`timescale 1ns/100ps

module fpRound16 import fp16Pkg::*; (
	input  logic       clk,
	input  logic       rstN,
	input  logic       ce,
	input  roundMode_t rm,
	input  FP16N       i,
	input  logic       special,
	output FP16        o,
	output logic       inexact
);

	localparam int sumW = EMSB + FMSB + 2;   // exponent and fraction together

	logic            lsb;
	logic            g;
	logic            r;
	logic            s;
	logic            anyLost;     // any of g, r, s
	logic            noRound;
	logic            rnd;
	logic            rndMode;
	logic [EMSB:0]   expIn;
	logic [sumW-1:0] sum;

	assign lsb = i.sig[3];
	assign g   = i.sig[2];      // guard
	assign r   = i.sig[1];      // round
	assign s   = i.sig[0];      // sticky
	assign anyLost = g | r | s;

	// infinities are never rounded
	assign noRound = (&i.exp) | special;

	// ------------------------------
	// increment decision
	// ------------------------------
	always_comb begin
		case (rm)
			rmNearestEven: rndMode = g & (r | s | lsb);   // above half, or tie with odd lsb
			rmZero:        rndMode = 1'b0;                // truncate
			rmPlusInf:     rndMode = anyLost & ~i.sign;
			rmMinusInf:    rndMode = anyLost & i.sign;
			rmNearestAway: rndMode = g;                   // half or more goes up
			default:       rndMode = 1'b0;
		endcase
	end

	assign rnd = rndMode & ~noRound;

	// subnormal leading bit folds into the exponent here
	assign expIn = (i.exp == '0) ? {{EMSB{1'b0}}, i.sig[FMSB+4]} : i.exp;

	// carry out of the fraction lands in the exponent, may reach inf
	assign sum = {expIn, i.sig[FMSB+3:3]} + sumW'(rnd);

	// ------------------------------
	// output register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rstN) begin
			o       <= '0;
			inexact <= 1'b0;
		end
		else if (ce) begin
			o.f.sign          <= i.sign;
			{o.f.exp, o.f.sig} <= sum;
			inexact           <= anyLost & ~noRound;   // finite inputs only
		end
	end

endmodule

/* hdl/fpClassify16.sv */
// flags are {zero, subnormal, infinite, overflow, inexact}, MSB first, valid only with outStrobe
`timescale 1ns/100ps

module fpClassify16 import fp16Pkg::*; (
	input  FP16        result,
	input  logic       inexact,
	input  logic       outStrobe,
	output logic [4:0] flags
);

	logic isZero;
	logic isSub;
	logic isInf;
	logic isOvf;

	// ------------------------------
	// field decode
	// ------------------------------
	assign isZero = (result.f.exp == '0) && (result.f.sig == '0);
	assign isSub  = (result.f.exp == '0) && (result.f.sig != '0);
	assign isInf  = &result.f.exp;             // fraction is always 0 here

	// inf that lost bits came from a finite value
	assign isOvf = isInf & inexact;

	// idle cycles show nothing
	assign flags = outStrobe ? {isZero, isSub, isInf, isOvf, inexact} : 5'b0;

endmodule

/* hdl/fpRoundCtrl.sv */
// no back-pressure; one item may enter per cycle and the mode is latched only with inStrobe
`timescale 1ns/100ps

module fpRoundCtrl import fp16Pkg::*; (
	input  logic       clk,
	input  logic       rstN,
	input  logic       inStrobe,
	input  roundMode_t inMode,
	output logic       stageCe1,
	output logic       stageCe2,
	output logic       outStrobe,
	output roundMode_t roundModeD1
);

	// ------------------------------
	// stage enables
	// ------------------------------

	// normalizer captures on the input strobe itself
	assign stageCe1 = inStrobe;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			stageCe2  <= 1'b0;
			outStrobe <= 1'b0;
		end
		else begin
			stageCe2  <= inStrobe;    // item sits in the normalizer register
			outStrobe <= stageCe2;    // item sits in the rounder register
		end
	end

	// ------------------------------
	// mode travels with its item
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rstN)
			roundModeD1 <= rmNearestEven;
		else if (inStrobe)
			roundModeD1 <= inMode;     // lines up with normWord
	end

endmodule

/* hdl/fpRoundUnit16.sv */
// two cycle latency from inStrobe to outStrobe; NaN inputs come in as inSpecial and leave as infinity
`timescale 1ns/100ps

module fpRoundUnit16 import fp16Pkg::*; #(
	parameter int rawWidth = 24
) (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          inStrobe,
	input  logic                          inSign,
	input  logic signed [expRawWidth-1:0] inExp,
	input  logic [rawWidth-1:0]           inMag,
	input  logic                          inSpecial,
	input  roundMode_t                    inMode,
	output logic                          outStrobe,
	output logic [MSB:0]                  result,
	output logic [4:0]                    flags
);

	logic       stageCe1;
	logic       stageCe2;
	roundMode_t roundModeD1;
	FP16N       normWord;
	logic       normSpecial;
	FP16        roundResult;
	logic       inexact;

	// ------------------------------
	// control spine
	// ------------------------------
	fpRoundCtrl uCtrl (
		.clk         (clk),
		.rstN        (rstN),
		.inStrobe    (inStrobe),
		.inMode      (inMode),
		.stageCe1    (stageCe1),
		.stageCe2    (stageCe2),
		.outStrobe   (outStrobe),
		.roundModeD1 (roundModeD1)
	);

	// ------------------------------
	// datapath
	// ------------------------------
	fpNormalize16 #(.rawWidth(rawWidth)) uNorm (
		.clk         (clk),
		.rstN        (rstN),
		.ce          (stageCe1),
		.sign        (inSign),
		.expRaw      (inExp),
		.mag         (inMag),
		.special     (inSpecial),
		.normWord    (normWord),
		.normSpecial (normSpecial)
	);

	fpRound16 uRound (
		.clk     (clk),
		.rstN    (rstN),
		.ce      (stageCe2),
		.rm      (roundModeD1),
		.i       (normWord),
		.special (normSpecial),
		.o       (roundResult),
		.inexact (inexact)
	);

	fpClassify16 uClass (
		.result    (roundResult),
		.inexact   (inexact),
		.outStrobe (outStrobe),
		.flags     (flags)
	);

	assign result = roundResult.raw;   // raw view of the rounded word

endmodule

/* verification/fpRoundUnit16_asserts.sv */
// handshake and flag rules at the top level only; data values are checked elsewhere
`timescale 1ns/100ps

module fpRoundUnit16_asserts (
	input logic       clk,
	input logic       rstN,
	input logic       inStrobe,
	input logic       outStrobe,
	input logic [4:0] flags
);

	// ------------------------------
	// strobe pipeline
	// ------------------------------
	strobeDelay: assert property (@(posedge clk) disable iff (!rstN)
		outStrobe == $past(inStrobe, 2))
		else $error("outStrobe does not follow inStrobe by two cycles");

	// no stale flags on idle cycles
	idleFlags: assert property (@(posedge clk) disable iff (!rstN)
		!outStrobe |-> flags == 5'b0)
		else $error("flags set while outStrobe is low");

	ovfIsInf: assert property (@(posedge clk) disable iff (!rstN)
		flags[1] |-> flags[2])                  // overflow without infinite
		else $error("overflow flag without infinite flag");

endmodule

bind fpRoundUnit16 fpRoundUnit16_asserts uAsserts (
	.clk       (clk),
	.rstN      (rstN),
	.inStrobe  (inStrobe),
	.outStrobe (outStrobe),
	.flags     (flags)
);

/* verification/fpRoundUnit16_tb.sv */
// model assumes rawWidth 24 and rounds from the exact input value; special inputs always expect infinity
`timescale 1ns/100ps
`include "fp16Defs.svh"

module fpRoundUnit16_tb import fp16Pkg::*; ();

	localparam int rawWidth  = 24;
	localparam int period    = 20;                      // ns
	localparam int tableLen  = 26;
	localparam int randCount = 200;

	typedef struct packed {
		logic                          sign;
		logic signed [expRawWidth-1:0] expRaw;
		logic [rawWidth-1:0]           mag;
		logic                          special;
		roundMode_t                    mode;
		logic [MSB:0]                  res;
		logic [4:0]                    flags;   // zero, sub, inf, ovf, inexact
	} vector_t;

	typedef struct packed {
		logic [31:0]  id;
		logic [31:0]  cyc;      // cycle of the input strobe
		logic [MSB:0] res;
		logic [4:0]   flags;
	} pending_t;

	logic clk = 1'b0;
	logic rstN;
	logic inStrobe;
	logic inSign;
	logic signed [expRawWidth-1:0] inExp;
	logic [rawWidth-1:0] inMag;
	logic inSpecial;
	roundMode_t inMode;
	logic outStrobe;
	logic [MSB:0] result;
	logic [4:0] flags;

	vector_t     vecs [tableLen];
	pending_t    pendQ [$];          // expected items in issue order
	pending_t    cur;
	logic [31:0] cycleCnt = '0;
	logic [31:0] rCtl;
	logic [31:0] rMag;
	logic [20:0] want;
	integer      seed = 39439;
	int          errors = 0;
	int          errBefore;
	int          testsRun = 0;
	int          testsFailed = 0;

	fpRoundUnit16 #(.rawWidth(rawWidth)) DUT (
		.clk       (clk),
		.rstN      (rstN),
		.inStrobe  (inStrobe),
		.inSign    (inSign),
		.inExp     (inExp),
		.inMag     (inMag),
		.inSpecial (inSpecial),
		.inMode    (inMode),
		.outStrobe (outStrobe),
		.result    (result),
		.flags     (flags)
	);

	always #(period / 2) clk = ~clk;
	always @(posedge clk) cycleCnt <= cycleCnt + 1;

	// ------------------------------
	// reference model
	// ------------------------------
	// value is mag * 2^(expRaw-23); the result lsb weighs 2^q, q fixed by the biased exponent
	function automatic logic [20:0] refRound(input logic sign, input logic signed [6:0] expRaw,
			input logic [rawWidth-1:0] mag, input logic special, input roundMode_t mode);
		int          p;
		int          biased;
		int          q;
		int          sh;
		logic [63:0] n;
		logic [63:0] rem;
		logic [63:0] half;
		logic        inc;
		logic        lost;
		logic [15:0] word;
		p = -1;
		lost = 1'b0;
		word = '0;                                          // zero magnitude gives +0
		for (int k = 0; k < rawWidth; k++)
			if (mag[k]) p = k;                              // leading one
		biased = int'(expRaw) - (rawWidth - 1 - p) + `fpBias;
		if (special || (mag != '0 && biased >= 31)) begin
			word = {sign, 15'h7C00};                        // saturate, no rounding
		end
		else if (mag != '0) begin
			q  = ((biased < 1) ? 1 : biased) - `fpBias - `fpFracWidth;
			sh = int'(expRaw) - (rawWidth - 1) - q;
			if (sh >= 0) begin
				n = 64'(mag) << sh;
				rem = '0;
				half = 64'd1;
			end
			else begin
				n = 64'(mag) >> (-sh);
				rem = 64'(mag) & ((64'd1 << (-sh)) - 64'd1);    // bits below the lsb
				half = 64'd1 << (-sh - 1);
			end
			lost = (rem != '0);
			case (mode)
				rmNearestEven: inc = (rem > half) || (rem == half && n[0]);
				rmZero:        inc = 1'b0;
				rmPlusInf:     inc = lost && !sign;
				rmMinusInf:    inc = lost && sign;
				default:       inc = (rem >= half);       // ties away
			endcase
			n = n + 64'(inc);
			// hidden bit of n adds into the exponent field, carry included
			word = {sign, 15'((((biased < 1) ? 0 : biased - 1) << `fpFracWidth) + int'(n))};
		end
		return {word, word[14:0] == '0, word[14:10] == '0 && word[9:0] != '0,
			&word[14:10], &word[14:10] && lost, lost};
	endfunction

	task automatic applyItem(input logic s, input logic signed [6:0] e, input logic [23:0] m,
			input logic sp, input roundMode_t md, input logic [15:0] res, input logic [4:0] fl,
			input int id);
		pending_t item;
		@(posedge clk);
		#2;
		inStrobe = 1'b1;
		inSign = s;
		inExp = e;
		inMag = m;
		inSpecial = sp;
		inMode = md;
		item = '{32'(id), cycleCnt, res, fl};
		pendQ.push_back(item);
	endtask

	// ------------------------------
	// output checker
	// ------------------------------
	always @(negedge clk) begin
		if (outStrobe) begin
			if (pendQ.size() == 0) begin
				$display("ERROR at %0t: outStrobe came with no item in flight", $time);
				errors++;
			end
			else begin
				cur = pendQ.pop_front();
				errBefore = errors;
				assert (cycleCnt - cur.cyc == 2) else begin
					$display("ERROR: test %0d came out %0d cycles after its strobe instead of 2",
						cur.id, cycleCnt - cur.cyc);
					errors++;
				end
				assert (result == cur.res && flags == cur.flags) else begin
					$display("MISMATCH at %0t: test %0d gave %h flags %b, expected %h flags %b",
						$time, cur.id, result, flags, cur.res, cur.flags);
					errors++;
				end
				testsRun++;
				if (errors != errBefore) testsFailed++;
				$display("test %0d %s: result %h flags %b", cur.id,
					(errors == errBefore) ? "ok" : "failed", result, flags);
			end
		end
	end

	initial begin
		#((tableLen + randCount + 20) * period);
		$display("timeout: the pipeline did not return all results in time");
		$display("sim failed");
		$finish;
	end

	initial begin
		// exact values in all modes
		vecs[0]  = '{1'b0, 7'sd0, 24'hC00000, 1'b0, rmNearestEven, 16'h3E00, 5'b00000};
		vecs[1]  = '{1'b0, 7'sd0, 24'hC00000, 1'b0, rmZero,        16'h3E00, 5'b00000};
		vecs[2]  = '{1'b0, 7'sd0, 24'hC00000, 1'b0, rmPlusInf,     16'h3E00, 5'b00000};
		vecs[3]  = '{1'b1, 7'sd0, 24'hC00000, 1'b0, rmMinusInf,    16'hBE00, 5'b00000};
		vecs[4]  = '{1'b1, 7'sd0, 24'hC00000, 1'b0, rmNearestAway, 16'hBE00, 5'b00000};
		// tie with even lsb, positive
		vecs[5]  = '{1'b0, 7'sd0, 24'h801000, 1'b0, rmNearestEven, 16'h3C00, 5'b00001};
		vecs[6]  = '{1'b0, 7'sd0, 24'h801000, 1'b0, rmNearestAway, 16'h3C01, 5'b00001};
		vecs[7]  = '{1'b0, 7'sd0, 24'h801000, 1'b0, rmZero,        16'h3C00, 5'b00001};
		vecs[8]  = '{1'b0, 7'sd0, 24'h801000, 1'b0, rmPlusInf,     16'h3C01, 5'b00001};
		vecs[9]  = '{1'b0, 7'sd0, 24'h801000, 1'b0, rmMinusInf,    16'h3C00, 5'b00001};
		// tie with odd lsb, negative
		vecs[10] = '{1'b1, 7'sd0, 24'h803000, 1'b0, rmNearestEven, 16'hBC02, 5'b00001};
		vecs[11] = '{1'b1, 7'sd0, 24'h803000, 1'b0, rmNearestAway, 16'hBC02, 5'b00001};
		vecs[12] = '{1'b1, 7'sd0, 24'h803000, 1'b0, rmPlusInf,     16'hBC01, 5'b00001};
		vecs[13] = '{1'b1, 7'sd0, 24'h803000, 1'b0, rmMinusInf,    16'hBC02, 5'b00001};
		vecs[14] = '{1'b1, 7'sd0, 24'h803000, 1'b0, rmZero,        16'hBC01, 5'b00001};
		vecs[15] = '{1'b0, 7'sd0, 24'h801001, 1'b0, rmNearestEven, 16'h3C01, 5'b00001};
		// carry into the exponent, up to infinity
		vecs[16] = '{1'b0, 7'sd0, 24'hFFF000, 1'b0, rmNearestEven, 16'h4000, 5'b00001};
		vecs[17] = '{1'b0, 7'sd15, 24'hFFF000, 1'b0, rmNearestEven, 16'h7C00, 5'b00111};
		vecs[18] = '{1'b0, 7'sd15, 24'hFFF000, 1'b0, rmZero,       16'h7BFF, 5'b00001};
		// subnormals and zero
		vecs[19] = '{1'b0, -7'sd15, 24'h800000, 1'b0, rmNearestEven, 16'h0200, 5'b01000};
		vecs[20] = '{1'b0, -7'sd24, 24'hC00000, 1'b0, rmNearestEven, 16'h0002, 5'b01001};
		vecs[21] = '{1'b0, -7'sd24, 24'hC00000, 1'b0, rmZero,        16'h0001, 5'b01001};
		vecs[22] = '{1'b0, -7'sd15, 24'hFFF000, 1'b0, rmNearestEven, 16'h0400, 5'b00001};
		vecs[23] = '{1'b1, 7'sd3, 24'h000000, 1'b0, rmNearestEven, 16'h0000, 5'b10000};
		// special input and exponent saturation
		vecs[24] = '{1'b1, 7'sd0, 24'h801001, 1'b1, rmNearestEven, 16'hFC00, 5'b00100};
		vecs[25] = '{1'b0, 7'sd16, 24'h800000, 1'b0, rmPlusInf,    16'h7C00, 5'b00100};

		inStrobe  = 1'b0;
		inSign    = 1'b0;
		inExp     = '0;
		inMag     = '0;
		inSpecial = 1'b0;
		inMode    = rmNearestEven;
		rstN      = 1'b0;
		repeat (5) @(posedge clk);
		#2 rstN = 1'b1;

		for (int k = 0; k < tableLen; k++)        // back to back, mode changes every item
			applyItem(vecs[k].sign, vecs[k].expRaw, vecs[k].mag, vecs[k].special,
				vecs[k].mode, vecs[k].res, vecs[k].flags, k);

		for (int k = 0; k < randCount; k++) begin
			rCtl = $random(seed);
			rMag = $random(seed);
			want = refRound(rCtl[4], 7'(int'(rCtl[21:16]) - 32), rMag[23:0] >> rCtl[27:24],
				rCtl[31:28] == 4'h0, roundMode_t'(3'(rCtl[15:8] % 8'd5)));
			applyItem(rCtl[4], 7'(int'(rCtl[21:16]) - 32), rMag[23:0] >> rCtl[27:24],
				rCtl[31:28] == 4'h0, roundMode_t'(3'(rCtl[15:8] % 8'd5)),
				want[20:5], want[4:0], tableLen + k);
		end

		@(posedge clk);
		#2 inStrobe = 1'b0;
		repeat (3) @(posedge clk);                 // latency two, plus margin
		@(negedge clk);
		if (pendQ.size() != 0)
			$display("ERROR: %0d items never got an outStrobe", pendQ.size());
		$display("%0d tests run, %0d failed, %0d errors, %0d missing",
			testsRun, testsFailed, errors, pendQ.size());
		if (errors == 0 && pendQ.size() == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* all.f */
+incdir+include
hdl/fp16Pkg.sv
hdl/fpNormalize16.sv
hdl/fpRound16.sv
hdl/fpClassify16.sv
hdl/fpRoundCtrl.sv
hdl/fpRoundUnit16.sv
verification/fpRoundUnit16_asserts.sv
verification/fpRoundUnit16_tb.sv

/* run.sh */
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module fpRoundUnit16_tb -o simv
./obj_dir/simv | tee sim.log
if grep -q "sim failed" sim.log; then
	exit 1
fi
